//--- sources.f
src/mem_ctrl_pkg.sv
src/sync_fifo.sv
src/bus_front.sv
src/read_return.sv
src/port_arbiter.sv
src/mem_array.sv
src/mem_ctrl_top.sv
sim/tb_clock.sv
sim/mem_ctrl_tb.sv

//--- sim/mem_ctrl_tb.sv
module mem_ctrl_tb;
    import mem_ctrl_pkg::*;

    localparam int timeout_cycles = 400;
    localparam int num_ops        = 60;

    logic  ui_clk, resetn, load_done, load_en, load_rdy;
    addr_t load_addr;
    data_t load_data;
    strb_t load_mask;
    logic  wr_valid, wr_ready, ar_valid, ar_ready;
    id_t   wr_id, ar_id, b_id, r_id;
    addr_t wr_addr, ar_addr;
    data_t wr_data, r_data;
    strb_t wr_strb;
    logic  b_valid, b_ready, r_valid, r_ready;
    data_t model [2**addr_w];   // expected memory contents
    id_t   exp_b_id [$];
    id_t   exp_r_id [$];
    data_t exp_r_data [$];
    logic [31:0] rng, ready_rng;
    int    ready_mode;          // 0 always ready, 1 random, 2 held low
    logic  b_hold, r_hold;
    id_t   held_b_id, held_r_id, i_v;
    data_t held_r_data, d_v;
    addr_t a_v;
    strb_t s_v;
    id_t   pend_id [req_depth];     // writes queued before load_done
    addr_t pend_addr [req_depth];
    data_t pend_data [req_depth];
    strb_t pend_strb [req_depth];
    int    n;

    tb_clock i_tb_clock (.ui_clk, .resetn);
    mem_ctrl_top i_mem_ctrl_top (.*);

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic data_t byte_bits(input strb_t m);
        data_t bits;
        for (int b = 0; b < strb_w; b++) begin
            bits[8*b +: 8] = {8{m[b]}};
        end
        return bits;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic timed_out(input string what);
        $display("timed out waiting for %s at time %0t", what, $time);
        abort_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] time %0t: %s got %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic load_word(input addr_t a, input data_t d, input strb_t m);
        check_value("load_rdy", load_rdy, 1'b1);
        load_en   = 1'b1;
        load_addr = a;
        load_data = d;
        load_mask = m;
        model[a]  = (model[a] & byte_bits(m)) | (d & ~byte_bits(m));   // mask keeps bytes
        @(negedge ui_clk);
        load_en = 1'b0;
    endtask

    task automatic send_write(input id_t i, input addr_t a, input data_t d, input strb_t s);
        int waited;
        waited   = 0;
        wr_valid = 1'b1;
        wr_id    = i;
        wr_addr  = a;
        wr_data  = d;
        wr_strb  = s;
        while (!wr_ready) begin
            @(negedge ui_clk);
            waited++;
            if (waited > timeout_cycles) timed_out("wr_ready");
        end
        exp_b_id.push_back(i);
        @(negedge ui_clk);
        wr_valid = 1'b0;
    endtask

    task automatic apply_write(input addr_t a, input data_t d, input strb_t s);
        model[a] = (model[a] & ~byte_bits(s)) | (d & byte_bits(s));
    endtask

    task automatic send_read(input id_t i, input addr_t a);
        int waited;
        waited   = 0;
        ar_valid = 1'b1;
        ar_id    = i;
        ar_addr  = a;
        while (!ar_ready) begin
            @(negedge ui_clk);
            waited++;
            if (waited > timeout_cycles) timed_out("ar_ready");
        end
        exp_r_id.push_back(i);
        exp_r_data.push_back(model[a]);   // model as it stands at acceptance
        @(negedge ui_clk);
        ar_valid = 1'b0;
    endtask

    task automatic wait_acks_done();
        int waited;
        waited = 0;
        while (exp_b_id.size() != 0) begin
            @(negedge ui_clk);
            waited++;
            if (waited > timeout_cycles) timed_out("write acknowledge");
        end
    endtask

    task automatic wait_reads_drained();
        int waited;
        waited = 0;
        while (exp_r_id.size() != 0) begin
            @(negedge ui_clk);
            waited++;
            if (waited > timeout_cycles) timed_out("read data");
        end
    endtask

    // response side: random ready, stability and in-order checks
    always @(negedge ui_clk) begin
        if (resetn === 1'b1) begin
            if (b_hold) begin
                check_value("b_valid", b_valid, 1'b1);
                check_value("b_id", b_id, held_b_id);
            end
            if (r_hold) begin
                check_value("r_valid", r_valid, 1'b1);
                check_value("r_id", r_id, held_r_id);
                check_value("r_data", r_data, held_r_data);
            end
            ready_rng = next_rand(ready_rng);
            b_ready   = (ready_mode == 0) || (ready_mode == 1 && ready_rng[1:0] != 2'b00);
            r_ready   = (ready_mode == 0) || (ready_mode == 1 && ready_rng[3:2] != 2'b00);
            if (b_valid && b_ready) begin
                if (exp_b_id.size() == 0) begin
                    $display("write acknowledge with no write outstanding at %0t", $time);
                    abort_run();
                end
                check_value("b_id", b_id, exp_b_id.pop_front());
            end
            if (r_valid && r_ready) begin
                if (exp_r_id.size() == 0) begin
                    $display("read data with no read outstanding at %0t", $time);
                    abort_run();
                end
                check_value("r_id", r_id, exp_r_id.pop_front());
                check_value("r_data", r_data, exp_r_data.pop_front());
            end
            b_hold      = b_valid && !b_ready;
            r_hold      = r_valid && !r_ready;
            held_b_id   = b_id;
            held_r_id   = r_id;
            held_r_data = r_data;
        end
    end

    initial begin
        load_done  = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        load_mask  = '0;
        wr_valid   = 1'b0;
        wr_id      = '0;
        wr_addr    = '0;
        wr_data    = '0;
        wr_strb    = '0;
        ar_valid   = 1'b0;
        ar_id      = '0;
        ar_addr    = '0;
        b_ready    = 1'b0;
        r_ready    = 1'b0;
        b_hold     = 1'b0;
        r_hold     = 1'b0;
        ready_mode = 0;
        rng        = 32'd1353;
        ready_rng  = next_rand(next_rand(32'd1353));
        n          = 0;
        while (resetn !== 1'b1) begin
            @(negedge ui_clk);
            n++;
            if (n > timeout_cycles) timed_out("reset release");
        end
        check_value("b_valid", b_valid, 1'b0);
        check_value("r_valid", r_valid, 1'b0);
        check_value("load_rdy", load_rdy, 1'b1);

        for (int a = 0; a < 2**addr_w; a++) begin   // every word gets a known value
            rng = next_rand(rng);
            load_word(addr_t'(a), rng, '0);
        end
        for (int k = 0; k < req_depth; k++) begin   // loader still owns memory
            rng          = next_rand(rng);
            pend_id[k]   = rng[3:0];
            pend_addr[k] = rng[11:4];
            pend_strb[k] = rng[15:12];
            rng          = next_rand(rng);
            pend_data[k] = rng;
            send_write(pend_id[k], pend_addr[k], pend_data[k], pend_strb[k]);
        end
        check_value("wr_ready", wr_ready, 1'b0);   // write queue full
        for (int k = 0; k < 20; k++) begin
            @(negedge ui_clk);
            check_value("b_valid", b_valid, 1'b0);
        end
        for (int k = 0; k < 24; k++) begin
            rng = next_rand(rng);
            a_v = rng[7:0];
            s_v = rng[11:8];
            rng = next_rand(rng);
            load_word(a_v, rng, s_v);
        end
        load_done = 1'b1;
        for (int k = 0; k < req_depth; k++) begin
            apply_write(pend_addr[k], pend_data[k], pend_strb[k]);
        end
        wait_acks_done();
        for (int k = 0; k < req_depth; k++) begin
            send_read(pend_id[k], pend_addr[k]);
        end
        for (int k = 0; k < 32; k++) begin   // back to back reads
            rng = next_rand(rng);
            send_read(rng[3:0], rng[11:4]);
        end
        wait_reads_drained();

        ready_mode = 1;
        for (int k = 0; k < num_ops; k++) begin
            rng = next_rand(rng);
            i_v = rng[3:0];
            a_v = addr_t'(rng[7:4]);   // small window so reads hit written words
            s_v = rng[11:8];
            d_v = next_rand(rng);
            if (rng[12]) begin
                wait_reads_drained();   // a queued read must not be overtaken
                send_write(i_v, a_v, d_v, s_v);
                apply_write(a_v, d_v, s_v);
                wait_acks_done();
            end else begin
                send_read(i_v, a_v);
            end
        end
        wait_reads_drained();

        ready_mode = 2;
        for (int k = 0; k < 2 * req_depth; k++) begin
            rng = next_rand(rng);
            send_read(rng[3:0], rng[11:4]);
        end
        n = 0;
        while (ar_ready) begin
            @(negedge ui_clk);
            n++;
            if (n > timeout_cycles) timed_out("ar_ready to fall with full queues");
        end
        ready_mode = 1;
        wait_reads_drained();
        wait_acks_done();

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- sim/tb_clock.sv
module tb_clock (
    output logic ui_clk,
    output logic resetn
);

    initial begin
        ui_clk = 1'b0;
        forever #50 ui_clk = ~ui_clk;   // period 100
    end

    initial begin
        resetn = 1'b0;
        repeat (10) @(posedge ui_clk);
        @(negedge ui_clk);
        resetn = 1'b1;
    end

endmodule

//--- src/mem_ctrl_top.sv
module mem_ctrl_top (
    input  logic                ui_clk,
    input  logic                resetn,
    input  logic                load_done,
    input  logic                load_en,
    input  mem_ctrl_pkg::addr_t load_addr,
    input  mem_ctrl_pkg::data_t load_data,
    input  mem_ctrl_pkg::strb_t load_mask,
    output logic                load_rdy,
    input  logic                wr_valid,
    output logic                wr_ready,
    input  mem_ctrl_pkg::id_t   wr_id,
    input  mem_ctrl_pkg::addr_t wr_addr,
    input  mem_ctrl_pkg::data_t wr_data,
    input  mem_ctrl_pkg::strb_t wr_strb,
    input  logic                ar_valid,
    output logic                ar_ready,
    input  mem_ctrl_pkg::id_t   ar_id,
    input  mem_ctrl_pkg::addr_t ar_addr,
    output logic                b_valid,
    input  logic                b_ready,
    output mem_ctrl_pkg::id_t   b_id,
    output logic                r_valid,
    input  logic                r_ready,
    output mem_ctrl_pkg::id_t   r_id,
    output mem_ctrl_pkg::data_t r_data
);
    import mem_ctrl_pkg::*;

    logic  bus_cmd_valid, bus_cmd_write, bus_cmd_grant;
    addr_t bus_cmd_addr;
    data_t bus_cmd_data;
    strb_t bus_cmd_strb;
    logic  rd_issue, rd_room;
    id_t   rd_issue_id;
    logic  mem_cmd_valid, mem_cmd_write;
    addr_t mem_cmd_addr;
    data_t mem_cmd_data;
    strb_t mem_cmd_strb;
    logic  mem_rd_valid;
    data_t mem_rd_data;

    bus_front i_bus_front (
        .ui_clk, .resetn,
        .wr_valid, .wr_ready, .wr_id, .wr_addr, .wr_data, .wr_strb,
        .ar_valid, .ar_ready, .ar_id, .ar_addr,
        .b_valid, .b_ready, .b_id,
        .bus_cmd_valid, .bus_cmd_write, .bus_cmd_addr, .bus_cmd_data, .bus_cmd_strb,
        .bus_cmd_grant,
        .rd_issue, .rd_issue_id, .rd_room
    );

    read_return i_read_return (
        .ui_clk, .resetn,
        .rd_issue, .rd_issue_id, .rd_room,
        .mem_rd_valid, .mem_rd_data,
        .r_valid, .r_ready, .r_id, .r_data
    );

    port_arbiter i_port_arbiter (
        .ui_clk, .resetn, .load_done,
        .load_en, .load_addr, .load_data, .load_mask, .load_rdy,
        .bus_cmd_valid, .bus_cmd_write, .bus_cmd_addr, .bus_cmd_data, .bus_cmd_strb,
        .bus_cmd_grant,
        .mem_cmd_valid, .mem_cmd_write, .mem_cmd_addr, .mem_cmd_data, .mem_cmd_strb
    );

    mem_array i_mem_array (
        .ui_clk, .resetn,
        .mem_cmd_valid, .mem_cmd_write, .mem_cmd_addr, .mem_cmd_data, .mem_cmd_strb,
        .mem_rd_valid, .mem_rd_data
    );

endmodule

//--- src/mem_array.sv
module mem_array (
    input  logic                ui_clk,
    input  logic                resetn,
    input  logic                mem_cmd_valid,
    input  logic                mem_cmd_write,
    input  mem_ctrl_pkg::addr_t mem_cmd_addr,
    input  mem_ctrl_pkg::data_t mem_cmd_data,
    input  mem_ctrl_pkg::strb_t mem_cmd_strb,
    output logic                mem_rd_valid,
    output mem_ctrl_pkg::data_t mem_rd_data
);
    import mem_ctrl_pkg::*;

    data_t                   words [2**addr_w];
    logic [read_latency-1:0] pipe_valid;
    data_t                   pipe_data [read_latency];

    always_ff @(posedge ui_clk) begin
        if (mem_cmd_valid && mem_cmd_write) begin
            for (int b = 0; b < strb_w; b++) begin
                if (mem_cmd_strb[b]) begin
                    words[mem_cmd_addr][8*b +: 8] <= mem_cmd_data[8*b +: 8];
                end
            end
        end
    end

    // read data pipe, one stage per cycle of latency
    always_ff @(posedge ui_clk) begin
        pipe_data[0] <= words[mem_cmd_addr];
        for (int s = 1; s < read_latency; s++) begin
            pipe_data[s] <= pipe_data[s-1];
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid <= {pipe_valid[read_latency-2:0], mem_cmd_valid & ~mem_cmd_write};
        end
    end

    assign mem_rd_valid = pipe_valid[read_latency-1];
    assign mem_rd_data  = pipe_data[read_latency-1];

endmodule

//--- src/port_arbiter.sv
module port_arbiter (
    input  logic                ui_clk,
    input  logic                resetn,
    input  logic                load_done,
    input  logic                load_en,
    input  mem_ctrl_pkg::addr_t load_addr,
    input  mem_ctrl_pkg::data_t load_data,
    input  mem_ctrl_pkg::strb_t load_mask,
    output logic                load_rdy,
    input  logic                bus_cmd_valid,
    input  logic                bus_cmd_write,
    input  mem_ctrl_pkg::addr_t bus_cmd_addr,
    input  mem_ctrl_pkg::data_t bus_cmd_data,
    input  mem_ctrl_pkg::strb_t bus_cmd_strb,
    output logic                bus_cmd_grant,
    output logic                mem_cmd_valid,
    output logic                mem_cmd_write,
    output mem_ctrl_pkg::addr_t mem_cmd_addr,
    output mem_ctrl_pkg::data_t mem_cmd_data,
    output mem_ctrl_pkg::strb_t mem_cmd_strb
);
    import mem_ctrl_pkg::*;

    grant_t issued;
    logic   load_take;

    assign load_rdy      = ~load_done;   // loader owns memory until done
    assign load_take     = load_en & load_rdy;
    assign bus_cmd_grant = load_done & bus_cmd_valid;
    assign mem_cmd_valid = (issued != grant_none);

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            issued <= grant_none;
        end else if (load_take) begin
            issued <= grant_loader;
        end else if (bus_cmd_grant) begin
            issued <= grant_bus;
        end else begin
            issued <= grant_none;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (load_take) begin
            mem_cmd_write <= 1'b1;
            mem_cmd_addr  <= load_addr;
            mem_cmd_data  <= load_data;
            mem_cmd_strb  <= ~load_mask;   // mask marks bytes to keep
        end else begin
            mem_cmd_write <= bus_cmd_write;
            mem_cmd_addr  <= bus_cmd_addr;
            mem_cmd_data  <= bus_cmd_data;
            mem_cmd_strb  <= bus_cmd_strb;
        end
    end

endmodule

//--- src/read_return.sv
module read_return (
    input  logic                ui_clk,
    input  logic                resetn,
    input  logic                rd_issue,
    input  mem_ctrl_pkg::id_t   rd_issue_id,
    output logic                rd_room,
    input  logic                mem_rd_valid,
    input  mem_ctrl_pkg::data_t mem_rd_data,
    output logic                r_valid,
    input  logic                r_ready,
    output mem_ctrl_pkg::id_t   r_id,
    output mem_ctrl_pkg::data_t r_data
);
    import mem_ctrl_pkg::*;

    id_t                       tag_head;
    logic [id_w+data_w-1:0]    resp_head;
    logic                      resp_empty;
    logic                      r_pop;
    logic [$clog2(resp_depth+1)-1:0] occupancy;   // tags plus responses

    sync_fifo #(.width(id_w), .depth(resp_depth)) i_tag_queue (
        .ui_clk   (ui_clk),
        .resetn   (resetn),
        .push     (rd_issue),
        .data_in  (rd_issue_id),
        .pull     (mem_rd_valid),   // oldest tag meets its data
        .data_out (tag_head),
        .full     (),
        .empty    ()
    );

    sync_fifo #(.width($bits(resp_head)), .depth(resp_depth)) i_resp_queue (
        .ui_clk   (ui_clk),
        .resetn   (resetn),
        .push     (mem_rd_valid),
        .data_in  ({tag_head, mem_rd_data}),
        .pull     (r_pop),
        .data_out (resp_head),
        .full     (),
        .empty    (resp_empty)
    );

    assign {r_id, r_data} = resp_head;
    assign r_valid = ~resp_empty;
    assign r_pop   = r_valid & r_ready;

    assign rd_room = (occupancy < resp_depth);   // counter bounds both queues

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            occupancy <= '0;
        end else begin
            case ({rd_issue, r_pop})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

endmodule

//--- src/bus_front.sv
module bus_front (
    input  logic                ui_clk,
    input  logic                resetn,
    input  logic                wr_valid,
    output logic                wr_ready,
    input  mem_ctrl_pkg::id_t   wr_id,
    input  mem_ctrl_pkg::addr_t wr_addr,
    input  mem_ctrl_pkg::data_t wr_data,
    input  mem_ctrl_pkg::strb_t wr_strb,
    input  logic                ar_valid,
    output logic                ar_ready,
    input  mem_ctrl_pkg::id_t   ar_id,
    input  mem_ctrl_pkg::addr_t ar_addr,
    output logic                b_valid,
    input  logic                b_ready,
    output mem_ctrl_pkg::id_t   b_id,
    output logic                bus_cmd_valid,
    output logic                bus_cmd_write,
    output mem_ctrl_pkg::addr_t bus_cmd_addr,
    output mem_ctrl_pkg::data_t bus_cmd_data,
    output mem_ctrl_pkg::strb_t bus_cmd_strb,
    input  logic                bus_cmd_grant,
    output logic                rd_issue,
    output mem_ctrl_pkg::id_t   rd_issue_id,
    input  logic                rd_room
);
    import mem_ctrl_pkg::*;

    logic [id_w+addr_w+data_w+strb_w-1:0] wq_head;
    logic [id_w+addr_w-1:0]               rq_head;
    id_t   wq_id;
    addr_t wq_addr;
    data_t wq_data;
    strb_t wq_strb;
    id_t   rq_id;
    addr_t rq_addr;
    logic  wq_full, wq_empty;
    logic  rq_full, rq_empty;
    logic  out_of_reset;
    logic  wr_pick;
    logic  rd_pick;

    assign {wq_id, wq_addr, wq_data, wq_strb} = wq_head;
    assign {rq_id, rq_addr} = rq_head;

    assign wr_ready = out_of_reset & ~wq_full;
    assign ar_ready = out_of_reset & ~rq_full;

    sync_fifo #(.width($bits(wq_head)), .depth(req_depth)) i_wr_queue (
        .ui_clk   (ui_clk),
        .resetn   (resetn),
        .push     (wr_valid & wr_ready),
        .data_in  ({wr_id, wr_addr, wr_data, wr_strb}),
        .pull     (bus_cmd_grant & wr_pick),
        .data_out (wq_head),
        .full     (wq_full),
        .empty    (wq_empty)
    );

    sync_fifo #(.width($bits(rq_head)), .depth(req_depth)) i_rd_queue (
        .ui_clk   (ui_clk),
        .resetn   (resetn),
        .push     (ar_valid & ar_ready),
        .data_in  ({ar_id, ar_addr}),
        .pull     (bus_cmd_grant & rd_pick),
        .data_out (rq_head),
        .full     (rq_full),
        .empty    (rq_empty)
    );

    // writes first, held off while an ack is pending
    assign wr_pick = ~wq_empty & ~b_valid;
    assign rd_pick = ~wr_pick & ~rq_empty & rd_room;

    assign bus_cmd_valid = wr_pick | rd_pick;
    assign bus_cmd_write = wr_pick;
    assign bus_cmd_addr  = wr_pick ? wq_addr : rq_addr;
    assign bus_cmd_data  = wq_data;
    assign bus_cmd_strb  = wq_strb;

    assign rd_issue    = bus_cmd_grant & rd_pick;
    assign rd_issue_id = rq_id;

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            out_of_reset <= 1'b0;
            b_valid      <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
            if (bus_cmd_grant && wr_pick) begin
                b_valid <= 1'b1;
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge ui_clk) begin
        if (bus_cmd_grant && wr_pick) begin
            b_id <= wq_id;   // held until the ack is taken
        end
    end

endmodule

//--- src/sync_fifo.sv
module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 4
) (
    input  logic             ui_clk,
    input  logic             resetn,
    input  logic             push,
    input  logic [width-1:0] data_in,
    input  logic             pull,
    output logic [width-1:0] data_out,
    output logic             full,
    output logic             empty
);

    logic [width-1:0]           items [depth];
    logic [$clog2(depth)-1:0]   wr_ptr;
    logic [$clog2(depth)-1:0]   rd_ptr;
    logic [$clog2(depth+1)-1:0] count;
    logic                       do_push;
    logic                       do_pull;

    assign do_push  = push & ~full;   // push on full is dropped
    assign do_pull  = pull & ~empty;
    assign full     = (count == depth);
    assign empty    = (count == 0);
    assign data_out = items[rd_ptr];  // head item

    always_ff @(posedge ui_clk) begin
        if (do_push) begin
            items[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge ui_clk) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pull) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

//--- src/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

    localparam int addr_w       = 8;   // word address, 256 words
    localparam int data_w       = 32;
    localparam int strb_w       = 4;   // one enable per byte
    localparam int id_w         = 4;
    localparam int req_depth    = 4;   // write and read request queues
    localparam int resp_depth   = 4;   // reads in flight plus buffered
    localparam int read_latency = 2;   // command at memory to read data

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [strb_w-1:0] strb_t;
    typedef logic [id_w-1:0]   id_t;

    // which port owns the command register
    typedef enum logic [1:0] {
        grant_none,
        grant_loader,
        grant_bus
    } grant_t;

endpackage
